//--- design/lsq_pkg.sv
`default_nettype none

package lsq_pkg;

    typedef logic [31:0] word_t;       // one memory word
    typedef logic [29:0] word_addr_t;  // byte address without the offset bits
    typedef logic [3:0]  byte_sel_t;   // one bit per byte lane

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_t;

    typedef enum logic [1:0] {
        ST_FREE    = 2'd0,  // slot empty
        ST_WAITING = 2'd1,  // dispatched, address unknown
        ST_READY   = 2'd2,  // address and data written
        ST_RETIRED = 2'd3   // committed by the pipeline, waits for memory
    } entry_state_t;

    // lanes touched by an access, accesses are naturally aligned
    function automatic byte_sel_t lane_mask(input logic [1:0] offset, input mem_size_t size);
        case (size)
            SIZE_BYTE: return byte_sel_t'(4'b0001 << offset);
            SIZE_HALF: return byte_sel_t'(4'b0011 << {offset[1], 1'b0});
            default:   return 4'b1111;
        endcase
    endfunction

    // move the low bytes of store data up into their lanes
    function automatic word_t place_data(input logic [1:0] offset, input mem_size_t size,
                                         input word_t data);
        case (size)
            SIZE_BYTE: return word_t'(data[7:0]) << {offset, 3'b000};
            SIZE_HALF: return word_t'(data[15:0]) << {offset[1], 4'b0000};
            default:   return data;
        endcase
    endfunction

    // pull the addressed bytes down to bit 0, zero extended
    function automatic word_t extract_data(input logic [1:0] offset, input mem_size_t size,
                                           input word_t data);
        word_t shifted;
        shifted = data >> {offset, 3'b000};
        case (size)
            SIZE_BYTE: return {24'b0, shifted[7:0]};
            SIZE_HALF: return {16'b0, shifted[15:0]};
            default:   return data;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- design/mem_req_if.sv
`timescale 1ns/100ps
`default_nettype none

// one requester's path to the memory arbiter
interface mem_req_if;
    import lsq_pkg::*;

    logic       req;    // held until done
    logic       we;     // 1 = write
    word_addr_t adr;
    byte_sel_t  sel;
    word_t      wdata;
    logic       done;   // single cycle, from the arbiter
    word_t      rdata;  // valid together with done

    modport requester (output req, we, adr, sel, wdata, input done, rdata);
    modport arbiter   (input req, we, adr, sel, wdata, output done, rdata);

endinterface

`default_nettype wire

//--- design/store_queue.sv
`timescale 1ns/100ps
`default_nettype none

module store_queue #(
    parameter int sq_depth = 8,
    localparam int idx_w = $clog2(sq_depth)
) (
    input  logic                 clock,
    input  logic                 reset,
    // dispatch side
    input  logic                 dispatch,
    output logic                 full,
    output logic [idx_w-1:0]     tail,
    // execute side
    input  logic                 exec_valid,
    input  logic [idx_w-1:0]     exec_idx,
    input  logic [31:0]          exec_addr,
    input  lsq_pkg::word_t       exec_data,
    input  lsq_pkg::mem_size_t   exec_size,
    // retire side
    input  logic                 retire,
    // forwarding search for the load unit
    input  lsq_pkg::word_addr_t  fwd_adr,
    input  logic [idx_w-1:0]     fwd_limit,
    output logic                 older_known,
    output lsq_pkg::byte_sel_t   fwd_sel,
    output lsq_pkg::word_t       fwd_data,
    // commit toward memory
    mem_req_if.requester         store_port
);
    import lsq_pkg::*;

    typedef logic [idx_w-1:0] idx_t;

    idx_t         head_q;      // oldest entry, next to commit
    idx_t         tail_q;      // next free slot
    idx_t         ret_q;       // oldest entry not yet retired
    logic [idx_w:0] count_q;   // occupied slots, 0..sq_depth

    entry_state_t state_q [sq_depth];
    word_addr_t   adr_q   [sq_depth];
    byte_sel_t    sel_q   [sq_depth];
    word_t        data_q  [sq_depth];

    logic pop;
    idx_t fwd_span;   // number of stores older than the load
    idx_t scan_idx;

    assign full = (count_q == (idx_w + 1)'(sq_depth));
    assign tail = tail_q;

    // head commits once the pipeline has retired it
    assign store_port.req   = (state_q[head_q] == ST_RETIRED);
    assign store_port.we    = 1'b1;
    assign store_port.adr   = adr_q[head_q];
    assign store_port.sel   = sel_q[head_q];
    assign store_port.wdata = data_q[head_q];

    assign pop = store_port.req & store_port.done;

    // control state
    always_ff @(posedge clock) begin
        if (reset) begin
            head_q  <= '0;
            tail_q  <= '0;
            ret_q   <= '0;
            count_q <= '0;
            for (int i = 0; i < sq_depth; i++) begin
                state_q[i] <= ST_FREE;
            end
        end else begin
            if (dispatch) begin
                state_q[tail_q] <= ST_WAITING;
                tail_q          <= tail_q + 1'b1;   // wraps, depth is a power of two
            end
            if (exec_valid) begin
                state_q[exec_idx] <= ST_READY;
            end
            if (retire) begin
                state_q[ret_q] <= ST_RETIRED;   // in order, always the oldest unretired
                ret_q          <= ret_q + 1'b1;
            end
            if (pop) begin
                state_q[head_q] <= ST_FREE;   // memory has taken the write
                head_q          <= head_q + 1'b1;
            end
            case ({dispatch, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // payload written by the execute port
    always_ff @(posedge clock) begin
        if (exec_valid) begin
            adr_q[exec_idx]  <= exec_addr[31:2];
            sel_q[exec_idx]  <= lane_mask(exec_addr[1:0], exec_size);
            data_q[exec_idx] <= place_data(exec_addr[1:0], exec_size, exec_data);
        end
    end

    // walk oldest to youngest, so a younger match overwrites an older lane
    // limit equal to head means nothing older is left
    always_comb begin
        older_known = 1'b1;
        fwd_sel     = '0;
        fwd_data    = '0;
        fwd_span    = fwd_limit - head_q;   // modulo depth
        scan_idx    = head_q;
        for (int k = 0; k < sq_depth; k++) begin
            scan_idx = head_q + idx_t'(k);
            if (k < int'(fwd_span) && state_q[scan_idx] != ST_FREE) begin
                if (state_q[scan_idx] == ST_WAITING) begin
                    older_known = 1'b0;   // unknown address may alias the load
                end else if (adr_q[scan_idx] == fwd_adr) begin
                    for (int b = 0; b < 4; b++) begin
                        if (sel_q[scan_idx][b]) begin
                            fwd_sel[b]        = 1'b1;
                            fwd_data[8*b +: 8] = data_q[scan_idx][8*b +: 8];
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- design/load_unit.sv
`timescale 1ns/100ps
`default_nettype none

module load_unit #(
    parameter int sq_depth = 8,
    localparam int idx_w = $clog2(sq_depth)
) (
    input  logic                 clock,
    input  logic                 reset,
    // load request
    input  logic                 load_valid,
    output logic                 load_ready,
    input  logic [31:0]          load_addr,
    input  lsq_pkg::mem_size_t   load_size,
    input  logic [idx_w-1:0]     load_sq_tail,
    // forwarding link to the store queue
    output lsq_pkg::word_addr_t  fwd_adr,
    output logic [idx_w-1:0]     fwd_limit,
    input  logic                 older_known,
    input  lsq_pkg::byte_sel_t   fwd_sel,
    input  lsq_pkg::word_t       fwd_data,
    // result toward the consumer
    output logic                 load_result_valid,
    output lsq_pkg::word_t       load_result_data,
    input  logic                 load_done,
    // memory read
    mem_req_if.requester         load_port
);
    import lsq_pkg::*;

    typedef enum logic [2:0] {
        L_IDLE,
        L_WAIT,     // older store addresses still unknown
        L_FWD,      // sample the forwarded lanes
        L_READ,     // memory read in flight
        L_COMPLETE  // hold result until consumed
    } load_state_t;

    load_state_t      state_q;
    word_addr_t       ld_adr_q;
    logic [1:0]       ld_off_q;
    mem_size_t        ld_size_q;
    logic [idx_w-1:0] ld_limit_q;   // queue tail seen at dispatch
    byte_sel_t        fsel_q;       // lanes taken from the queue
    word_t            fdata_q;
    word_t            result_q;

    byte_sel_t need;
    logic      covered;
    word_t     merged;

    assign need    = lane_mask(ld_off_q, ld_size_q);
    assign covered = ((fwd_sel & need) == need);

    // queue bytes win over memory bytes
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            merged[8*b +: 8] = fsel_q[b] ? fdata_q[8*b +: 8] : load_port.rdata[8*b +: 8];
        end
    end

    assign load_ready        = (state_q == L_IDLE);
    assign load_result_valid = (state_q == L_COMPLETE);
    assign load_result_data  = result_q;
    assign fwd_adr           = ld_adr_q;
    assign fwd_limit         = ld_limit_q;

    assign load_port.req   = (state_q == L_READ);
    assign load_port.we    = 1'b0;
    assign load_port.adr   = ld_adr_q;
    assign load_port.sel   = need;
    assign load_port.wdata = '0;   // reads carry no data

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q <= L_IDLE;
        end else begin
            case (state_q)
                L_IDLE:     if (load_valid) state_q <= L_WAIT;
                L_WAIT:     if (older_known) state_q <= L_FWD;
                L_FWD:      state_q <= covered ? L_COMPLETE : L_READ;
                L_READ:     if (load_port.done) state_q <= L_COMPLETE;
                L_COMPLETE: if (load_done) state_q <= L_IDLE;
                default:    state_q <= L_IDLE;
            endcase
        end
    end

    // accepted load and the data path registers
    always_ff @(posedge clock) begin
        if (state_q == L_IDLE && load_valid) begin
            ld_adr_q   <= load_addr[31:2];
            ld_off_q   <= load_addr[1:0];
            ld_size_q  <= load_size;
            ld_limit_q <= load_sq_tail;
        end
        if (state_q == L_FWD) begin
            fsel_q  <= fwd_sel;
            fdata_q <= fwd_data;
            if (covered) begin
                result_q <= extract_data(ld_off_q, ld_size_q, fwd_data);   // no memory access
            end
        end
        if (state_q == L_READ && load_port.done) begin
            result_q <= extract_data(ld_off_q, ld_size_q, merged);
        end
    end

endmodule

`default_nettype wire

//--- design/mem_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter (
    input  logic                 clock,
    input  logic                 reset,
    // requesters
    mem_req_if.arbiter           store_port,
    mem_req_if.arbiter           load_port,
    // wishbone classic master
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output logic                 wb_we,
    output lsq_pkg::word_addr_t  wb_adr,
    output lsq_pkg::byte_sel_t   wb_sel,
    output lsq_pkg::word_t       wb_dat_w,
    input  logic                 wb_ack,
    input  lsq_pkg::word_t       wb_dat_r
);
    import lsq_pkg::*;

    logic busy_q;        // a bus cycle is open
    logic gnt_store_q;   // 1 = store port owns the cycle

    // grant only from idle, so the cycle after an ack always stays idle
    always_ff @(posedge clock) begin
        if (reset) begin
            busy_q      <= 1'b0;
            gnt_store_q <= 1'b0;
        end else if (busy_q) begin
            if (wb_ack) busy_q <= 1'b0;
        end else if (store_port.req) begin
            busy_q      <= 1'b1;
            gnt_store_q <= 1'b1;   // commits go first
        end else if (load_port.req) begin
            busy_q      <= 1'b1;
            gnt_store_q <= 1'b0;
        end
    end

    assign wb_cyc   = busy_q;
    assign wb_stb   = busy_q;
    assign wb_we    = busy_q & (gnt_store_q ? store_port.we : load_port.we);
    assign wb_adr   = gnt_store_q ? store_port.adr : load_port.adr;
    assign wb_sel   = gnt_store_q ? store_port.sel : load_port.sel;
    assign wb_dat_w = gnt_store_q ? store_port.wdata : load_port.wdata;

    // done and read data back to the owner only
    assign store_port.done  = busy_q & wb_ack & gnt_store_q;
    assign load_port.done   = busy_q & wb_ack & ~gnt_store_q;
    assign store_port.rdata = gnt_store_q ? wb_dat_r : '0;
    assign load_port.rdata  = gnt_store_q ? '0 : wb_dat_r;

endmodule

`default_nettype wire

//--- design/lsq.sv
`timescale 1ns/100ps
`default_nettype none

module lsq #(
    parameter int sq_depth = 8,
    localparam int idx_w = $clog2(sq_depth)
) (
    input  logic                 clock,
    input  logic                 reset,
    // store dispatch, execute and retire
    input  logic                 store_dispatch,
    output logic                 full,
    output logic [idx_w-1:0]     store_tail,
    input  logic                 store_exec_valid,
    input  logic [idx_w-1:0]     store_exec_idx,
    input  logic [31:0]          store_exec_addr,
    input  lsq_pkg::word_t       store_exec_data,
    input  lsq_pkg::mem_size_t   store_exec_size,
    input  logic                 store_retire,
    // load
    input  logic                 load_valid,
    output logic                 load_ready,
    input  logic [31:0]          load_addr,
    input  lsq_pkg::mem_size_t   load_size,
    input  logic [idx_w-1:0]     load_sq_tail,
    output logic                 load_result_valid,
    output lsq_pkg::word_t       load_result_data,
    input  logic                 load_done,
    // wishbone
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output logic                 wb_we,
    output lsq_pkg::word_addr_t  wb_adr,
    output lsq_pkg::byte_sel_t   wb_sel,
    output lsq_pkg::word_t       wb_dat_w,
    input  logic                 wb_ack,
    input  lsq_pkg::word_t       wb_dat_r
);
    import lsq_pkg::*;

    mem_req_if store_port ();
    mem_req_if load_port ();

    // forwarding link
    word_addr_t       fwd_adr;
    logic [idx_w-1:0] fwd_limit;
    logic             older_known;
    byte_sel_t        fwd_sel;
    word_t            fwd_data;

    store_queue #(.sq_depth(sq_depth)) u_store_queue (
        .clock       (clock),
        .reset       (reset),
        .dispatch    (store_dispatch),
        .full        (full),
        .tail        (store_tail),
        .exec_valid  (store_exec_valid),
        .exec_idx    (store_exec_idx),
        .exec_addr   (store_exec_addr),
        .exec_data   (store_exec_data),
        .exec_size   (store_exec_size),
        .retire      (store_retire),
        .fwd_adr     (fwd_adr),
        .fwd_limit   (fwd_limit),
        .older_known (older_known),
        .fwd_sel     (fwd_sel),
        .fwd_data    (fwd_data),
        .store_port  (store_port.requester)
    );

    load_unit #(.sq_depth(sq_depth)) u_load_unit (
        .clock             (clock),
        .reset             (reset),
        .load_valid        (load_valid),
        .load_ready        (load_ready),
        .load_addr         (load_addr),
        .load_size         (load_size),
        .load_sq_tail      (load_sq_tail),
        .fwd_adr           (fwd_adr),
        .fwd_limit         (fwd_limit),
        .older_known       (older_known),
        .fwd_sel           (fwd_sel),
        .fwd_data          (fwd_data),
        .load_result_valid (load_result_valid),
        .load_result_data  (load_result_data),
        .load_done         (load_done),
        .load_port         (load_port.requester)
    );

    mem_arbiter u_mem_arbiter (
        .clock      (clock),
        .reset      (reset),
        .store_port (store_port.arbiter),
        .load_port  (load_port.arbiter),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_sel     (wb_sel),
        .wb_dat_w   (wb_dat_w),
        .wb_ack     (wb_ack),
        .wb_dat_r   (wb_dat_r)
    );

endmodule

`default_nettype wire

//--- bench/lsq_chk.sv
`timescale 1ns/100ps
`default_nettype none

// bus and handshake rules of the lsq top level
module lsq_chk (
    input logic                clock,
    input logic                reset,
    input logic                store_dispatch,
    input logic                full,
    input logic                load_result_valid,
    input logic                load_done,
    input logic                wb_cyc,
    input logic                wb_stb,
    input logic                wb_we,
    input logic                wb_ack,
    input lsq_pkg::word_addr_t wb_adr,
    input lsq_pkg::byte_sel_t  wb_sel,
    input lsq_pkg::word_t      wb_dat_w
);
    int fail_count = 0;   // failed properties so far

    stb_in_cycle: assert property (@(posedge clock) disable iff (reset) wb_stb |-> wb_cyc)
        else begin
            $error("wb_stb high without wb_cyc");
            fail_count++;
        end

    // a classic cycle holds its request until the slave acks
    bus_stable: assert property (@(posedge clock) disable iff (reset)
        (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_we) && $stable(wb_adr)
                                 && $stable(wb_sel) && $stable(wb_dat_w)))
        else begin
            $error("wishbone request changed before ack");
            fail_count++;
        end

    no_dispatch_full: assert property (@(posedge clock) disable iff (reset)
        !(store_dispatch && full))
        else begin
            $error("store dispatched into a full queue");
            fail_count++;
        end

    result_held: assert property (@(posedge clock) disable iff (reset)
        (load_result_valid && !load_done) |=> load_result_valid)
        else begin
            $error("load result dropped before load_done");
            fail_count++;
        end

endmodule

bind lsq lsq_chk u_lsq_chk (.*);

`default_nettype wire

//--- bench/lsq_tb.sv
`timescale 1ns/100ps
`default_nettype none

module lsq_tb;
    import lsq_pkg::*;

    localparam int sq_depth = 8;
    localparam int idx_w = $clog2(sq_depth);

    typedef enum logic [2:0] {
        OP_DISPATCH, OP_EXEC, OP_RETIRE, OP_LOAD, OP_RESULT, OP_IDLE, OP_DRAIN
    } op_t;

    typedef struct packed {
        op_t              op;
        logic [idx_w-1:0] idx;
        logic [31:0]      addr;
        word_t            data;
        mem_size_t        size;
        word_t            exp_val;   // load result, or {full, tail} after a dispatch
        logic [3:0]       hold;      // cycles to withhold load_done, or idle cycles
        logic             fwd;       // load must complete from the queue alone
    } row_t;

    logic clock = 1'b0;
    logic reset, store_dispatch, store_exec_valid, store_retire, load_valid, load_done;
    logic full, load_ready, load_result_valid, wb_cyc, wb_stb, wb_we;
    logic [idx_w-1:0] store_tail, store_exec_idx, load_sq_tail;
    logic [31:0] store_exec_addr, load_addr;
    word_t store_exec_data, load_result_data, wb_dat_w;
    mem_size_t store_exec_size, load_size;
    word_addr_t wb_adr;
    byte_sel_t wb_sel;
    logic wb_ack = 1'b0;
    word_t wb_dat_r = '0;

    row_t rows [$];
    word_t mem [64];
    word_addr_t mdl_adr [sq_depth];   // expected commit per queue slot
    byte_sel_t mdl_sel [sq_depth];
    word_t mdl_data [sq_depth];
    logic [idx_w-1:0] mdl_head = '0;
    logic [idx_w-1:0] tb_tail = '0;
    int committed = 0;
    int dispatched = 0;
    int rd_count = 0;
    int cycles = 0;
    int cycle_limit = 0;
    int accept_cycle, reads_before;
    int wait_left = -1;
    integer seed = 42837;

    lsq #(.sq_depth(sq_depth)) u_lsq (.*);

    always #50 clock = ~clock;

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: test did not finish within %0d cycles", cycle_limit);
            $display("Finished with errors");
            $fatal(1);
        end
    end

    // a failed bus or handshake property ends the run at once
    always @(negedge clock) begin
        if (u_lsq.u_lsq_chk.fail_count != 0) begin
            $display("a bus or handshake assertion failed");
            $display("Finished with errors");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            $display("error %s: expected %h, actual %h", name, exp_v, act_v);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    // lanes from offset and byte count
    function automatic byte_sel_t lanes_of(input logic [1:0] off, input mem_size_t size);
        int n;
        byte_sel_t m;
        n = (size == SIZE_BYTE) ? 1 : ((size == SIZE_HALF) ? 2 : 4);
        for (int b = 0; b < 4; b++) begin
            m[b] = (b >= int'(off)) && (b < int'(off) + n);
        end
        return m;
    endfunction

    function automatic word_t placed_bytes(input logic [1:0] off, input mem_size_t size,
                                           input word_t data);
        byte_sel_t m;
        word_t w;
        m = lanes_of(off, size);
        w = '0;
        for (int b = 0; b < 4; b++) begin
            if (m[b]) w[8*b +: 8] = data[8*(b - int'(off)) +: 8];   // low byte goes to first lane
        end
        return w;
    endfunction

    // slave side write, checked against program order
    task automatic commit_write();
        string name;
        name = $sformatf("commit %0d", committed);
        check_value({name, " adr"}, mdl_adr[mdl_head], wb_adr);
        check_value({name, " sel"}, mdl_sel[mdl_head], wb_sel);
        check_value({name, " data"}, mdl_data[mdl_head], wb_dat_w);
        for (int b = 0; b < 4; b++) begin
            if (wb_sel[b]) mem[wb_adr[5:0]][8*b +: 8] = wb_dat_w[8*b +: 8];
        end
        mdl_head = mdl_head + 1'b1;
        committed++;
    endtask

    // wishbone memory, 0 to 3 wait cycles per access
    always @(negedge clock) begin
        if (reset) begin
            wb_ack <= 1'b0;
            wait_left = -1;
            for (int a = 0; a < 64; a++) begin
                mem[a] = a * 32'h01010101;
            end
        end else if (wb_ack) begin
            wb_ack <= 1'b0;   // master closes the cycle now
        end else if (wb_cyc && wb_stb) begin
            if (wait_left < 0) wait_left = $random(seed) & 3;
            if (wait_left > 0) begin
                wait_left = wait_left - 1;
            end else begin
                wait_left = -1;
                wb_ack <= 1'b1;
                if (wb_we) begin
                    commit_write();
                end else begin
                    wb_dat_r <= mem[wb_adr[5:0]];
                    rd_count++;
                end
            end
        end
    end

    task automatic add_row(input op_t op, input logic [idx_w-1:0] idx, input logic [31:0] addr,
                           input word_t data, input mem_size_t size, input word_t exp_val,
                           input int hold, input logic fwd);
        rows.push_back({op, idx, addr, data, size, exp_val, 4'(hold), fwd});
    endtask

    task automatic build_table();
        // fill the queue, tail wraps to 0 and full rises on the eighth
        for (int i = 1; i <= 8; i++) begin
            add_row(OP_DISPATCH, 0, 0, 0, SIZE_WORD, (i == 8) ? 32'h10 : i, 0, 0);
        end
        add_row(OP_EXEC, 0, 32'h10, 32'hA0A1A2A3, SIZE_WORD, 0, 0, 0);
        add_row(OP_EXEC, 1, 32'h15, 32'h000000B1, SIZE_BYTE, 0, 0, 0);
        add_row(OP_EXEC, 3, 32'h14, 32'h0000D1D2, SIZE_HALF, 0, 0, 0);   // out of order
        add_row(OP_EXEC, 2, 32'h1A, 32'h0000C2C3, SIZE_HALF, 0, 0, 0);
        add_row(OP_EXEC, 4, 32'h13, 32'h000000E4, SIZE_BYTE, 0, 0, 0);
        add_row(OP_EXEC, 5, 32'h20, 32'h12345678, SIZE_WORD, 0, 0, 0);
        add_row(OP_EXEC, 7, 32'h1C, 32'h00000077, SIZE_BYTE, 0, 0, 0);
        add_row(OP_EXEC, 6, 32'h22, 32'hFFFF9ABC, SIZE_HALF, 0, 0, 0);   // upper half ignored
        for (int i = 0; i < 8; i++) begin
            add_row(OP_RETIRE, 0, 0, 0, SIZE_WORD, 0, 0, 0);
        end
        add_row(OP_DRAIN, 0, 0, 0, SIZE_WORD, 0, 0, 0);
        // word 12 fully covered by two unretired stores
        add_row(OP_DISPATCH, 0, 0, 0, SIZE_WORD, 32'h01, 0, 0);
        add_row(OP_EXEC, 0, 32'h30, 32'h11223344, SIZE_WORD, 0, 0, 0);
        add_row(OP_DISPATCH, 0, 0, 0, SIZE_WORD, 32'h02, 0, 0);
        add_row(OP_EXEC, 1, 32'h31, 32'h00000055, SIZE_BYTE, 0, 0, 0);
        add_row(OP_LOAD, 0, 32'h30, 0, SIZE_WORD, 0, 0, 0);
        add_row(OP_RESULT, 0, 0, 0, SIZE_WORD, 32'h11225544, 0, 1);
        add_row(OP_LOAD, 0, 32'h32, 0, SIZE_HALF, 0, 0, 0);
        add_row(OP_RESULT, 0, 0, 0, SIZE_WORD, 32'h00001122, 4, 1);   // consumer stalls
        // one lane of word 5 from the queue, the rest from memory
        add_row(OP_DISPATCH, 0, 0, 0, SIZE_WORD, 32'h03, 0, 0);
        add_row(OP_EXEC, 2, 32'h16, 32'h00000066, SIZE_BYTE, 0, 0, 0);
        add_row(OP_LOAD, 0, 32'h14, 0, SIZE_WORD, 0, 0, 0);
        add_row(OP_RESULT, 0, 0, 0, SIZE_WORD, 32'h0566D1D2, 0, 0);
        add_row(OP_LOAD, 0, 32'h10, 0, SIZE_WORD, 0, 0, 0);
        add_row(OP_RESULT, 0, 0, 0, SIZE_WORD, 32'hE4A1A2A3, 0, 0);
        add_row(OP_LOAD, 0, 32'h1A, 0, SIZE_HALF, 0, 0, 0);
        add_row(OP_RESULT, 0, 0, 0, SIZE_WORD, 32'h0000C2C3, 0, 0);
        add_row(OP_LOAD, 0, 32'h20, 0, SIZE_WORD, 0, 0, 0);
        add_row(OP_RESULT, 0, 0, 0, SIZE_WORD, 32'h9ABC5678, 0, 0);
        for (int i = 0; i < 3; i++) begin
            add_row(OP_RETIRE, 0, 0, 0, SIZE_WORD, 0, 0, 0);
        end
        add_row(OP_DRAIN, 0, 0, 0, SIZE_WORD, 0, 0, 0);
        // older store address still unknown, load has to wait
        add_row(OP_DISPATCH, 0, 0, 0, SIZE_WORD, 32'h04, 0, 0);
        add_row(OP_LOAD, 0, 32'h30, 0, SIZE_WORD, 0, 0, 0);
        add_row(OP_IDLE, 0, 0, 0, SIZE_WORD, 0, 5, 0);
        add_row(OP_EXEC, 3, 32'h33, 32'h00000099, SIZE_BYTE, 0, 0, 0);
        add_row(OP_RESULT, 0, 0, 0, SIZE_WORD, 32'h99225544, 0, 0);
        add_row(OP_RETIRE, 0, 0, 0, SIZE_WORD, 0, 0, 0);
        add_row(OP_DRAIN, 0, 0, 0, SIZE_WORD, 0, 0, 0);
        add_row(OP_LOAD, 0, 32'h33, 0, SIZE_BYTE, 0, 0, 0);
        add_row(OP_RESULT, 0, 0, 0, SIZE_WORD, 32'h00000099, 0, 0);
    endtask

    task automatic apply_row(input int r);
        row_t row;
        string name;
        row = rows[r];
        name = $sformatf("row %0d", r);
        case (row.op)
            OP_DISPATCH: begin
                store_dispatch = 1'b1;
                @(negedge clock);
                store_dispatch = 1'b0;
                tb_tail = tb_tail + 1'b1;
                dispatched++;
                check_value({name, " tail"}, row.exp_val[idx_w-1:0], store_tail);
                check_value({name, " full"}, row.exp_val[4], full);
            end
            OP_EXEC: begin
                mdl_adr[row.idx]  = row.addr[31:2];
                mdl_sel[row.idx]  = lanes_of(row.addr[1:0], row.size);
                mdl_data[row.idx] = placed_bytes(row.addr[1:0], row.size, row.data);
                store_exec_valid = 1'b1;
                store_exec_idx   = row.idx;
                store_exec_addr  = row.addr;
                store_exec_data  = row.data;
                store_exec_size  = row.size;
                @(negedge clock);
                store_exec_valid = 1'b0;
            end
            OP_RETIRE: begin
                store_retire = 1'b1;
                @(negedge clock);
                store_retire = 1'b0;
            end
            OP_LOAD: begin
                while (!load_ready) @(negedge clock);
                load_valid   = 1'b1;
                load_addr    = row.addr;
                load_size    = row.size;
                load_sq_tail = tb_tail;   // stores dispatched so far are older
                accept_cycle = cycles + 1;
                reads_before = rd_count;
                @(negedge clock);
                load_valid = 1'b0;
            end
            OP_RESULT: begin
                while (!load_result_valid) @(negedge clock);
                if (row.fwd) begin
                    check_value({name, " latency"}, 2, cycles - accept_cycle);
                    check_value({name, " memory reads"}, reads_before, rd_count);
                end
                check_value({name, " data"}, row.exp_val, load_result_data);
                repeat (row.hold) begin
                    @(negedge clock);
                    check_value({name, " held valid"}, 1, load_result_valid);
                    check_value({name, " held data"}, row.exp_val, load_result_data);
                    check_value({name, " ready while held"}, 0, load_ready);
                end
                load_done = 1'b1;
                @(negedge clock);
                load_done = 1'b0;
                check_value({name, " ready after done"}, 1, load_ready);
            end
            OP_IDLE: begin
                repeat (row.hold) begin
                    @(negedge clock);
                    check_value({name, " early result"}, 0, load_result_valid);
                    check_value({name, " early bus cycle"}, 0, wb_cyc);
                end
            end
            default: begin
                while (committed != dispatched) @(negedge clock);
                repeat (2) @(negedge clock);   // pop lands one clock after ack
                check_value({name, " full"}, 0, full);
                check_value({name, " bus idle"}, 0, wb_cyc);
            end
        endcase
    endtask

    initial begin
        reset            = 1'b1;
        store_dispatch   = 1'b0;
        store_exec_valid = 1'b0;
        store_exec_idx   = '0;
        store_exec_addr  = '0;
        store_exec_data  = '0;
        store_exec_size  = SIZE_WORD;
        store_retire     = 1'b0;
        load_valid       = 1'b0;
        load_addr        = '0;
        load_size        = SIZE_WORD;
        load_sq_tail     = '0;
        load_done        = 1'b0;
        build_table();
        cycle_limit = 40 * rows.size() + 100;
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        check_value("reset full", 0, full);
        check_value("reset wb_cyc", 0, wb_cyc);
        check_value("reset wb_stb", 0, wb_stb);
        check_value("reset wb_we", 0, wb_we);
        check_value("reset result valid", 0, load_result_valid);
        check_value("reset load ready", 1, load_ready);
        check_value("reset tail", 0, store_tail);
        for (int r = 0; r < rows.size(); r++) begin
            apply_row(r);
        end
        repeat (2) @(negedge clock);
        if (u_lsq.u_lsq_chk.fail_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("%0d assertion failures", u_lsq.u_lsq_chk.fail_count);
            $display("Finished with errors");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

//--- files.f
design/lsq_pkg.sv
design/mem_req_if.sv
design/store_queue.sv
design/load_unit.sv
design/mem_arbiter.sv
design/lsq.sv
bench/lsq_chk.sv
bench/lsq_tb.sv

//--- Bender.yml
package:
  name: lsq

sources:
  - design/lsq_pkg.sv
  - design/mem_req_if.sv
  - design/store_queue.sv
  - design/load_unit.sv
  - design/mem_arbiter.sv
  - design/lsq.sv
  - target: test
    files:
      - bench/lsq_chk.sv
      - bench/lsq_tb.sv
